// File: hw/vga_config_regs.sv
`default_nettype none

module vga_config_regs (
  input  wire logic              wb_clk_i,
  input  wire logic              reset_i,
  input  wire vga_pkg::wb_req_t  req_i,
  input  wire logic              vblank_i,
  output logic [15:0]            dat_o,
  output logic                   ack_o,
  output vga_pkg::vga_cfg_t      cfg_o,
  output vga_pkg::pal_wr_t       pal_wr_o
);

  logic [1:0]                  mode_q;
  logic [15:0]                 bitmask_q;
  logic [vga_pkg::VRAM_AW-1:0] start_q;
  logic [3:0]                  pal_idx_q;
  logic [11:0]                 pal_shadow [16];
  logic                        pal_we_q;
  logic [3:0]                  pal_wr_idx_q;
  logic [11:0]                 pal_wr_color_q;
  vga_pkg::cfg_reg_e           reg_sel;
  logic [15:0]                 rd_val;
  logic [15:0]                 wr_val;
  logic                        access;
  logic                        wr_en;
  logic                        pal_hit;

  function automatic logic [15:0] merge_bytes(input logic [15:0] old_val,
                                              input logic [15:0] new_val,
                                              input logic [1:0]  sel);
    logic [15:0] res;
    res[15:8] = sel[1] ? new_val[15:8] : old_val[15:8];
    res[7:0]  = sel[0] ? new_val[7:0] : old_val[7:0];
    return res;
  endfunction

  assign reg_sel = vga_pkg::cfg_reg_e'(req_i.adr[vga_pkg::CFG_AW-1:0]);

  // Ack one cycle after the strobe and never back to back
  assign access  = req_i.stb & ~ack_o;
  assign wr_en   = access & req_i.we;
  assign pal_hit = wr_en && (reg_sel == vga_pkg::CFG_PAL_DATA);

  always_comb begin
    rd_val = '0;
    case (reg_sel)
      vga_pkg::CFG_MODE:      rd_val = {14'h0, mode_q};
      vga_pkg::CFG_BITMASK:   rd_val = bitmask_q;
      vga_pkg::CFG_START:     rd_val = {{(16 - vga_pkg::VRAM_AW){1'b0}}, start_q};
      vga_pkg::CFG_PAL_INDEX: rd_val = {12'h0, pal_idx_q};
      vga_pkg::CFG_PAL_DATA:  rd_val = {4'h0, pal_shadow[pal_idx_q]};
      vga_pkg::CFG_STATUS:    rd_val = {15'h0, vblank_i};
      default:                rd_val = '0;
    endcase
  end

  // Unselected bytes keep the current contents
  assign wr_val = merge_bytes(rd_val, req_i.dat, req_i.sel);

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_o     <= 1'b0;
      mode_q    <= 2'b00;
      bitmask_q <= 16'h0;
      start_q   <= '0;
      pal_idx_q <= 4'h0;
      pal_we_q  <= 1'b0;
    end else begin
      ack_o    <= access;
      pal_we_q <= pal_hit;
      if (wr_en) begin
        case (reg_sel)
          vga_pkg::CFG_MODE:      mode_q <= wr_val[1:0];
          vga_pkg::CFG_BITMASK:   bitmask_q <= wr_val;
          vga_pkg::CFG_START:     start_q <= wr_val[vga_pkg::VRAM_AW-1:0];
          vga_pkg::CFG_PAL_INDEX: pal_idx_q <= wr_val[3:0];
          // Auto increment for streaming palette loads
          vga_pkg::CFG_PAL_DATA:  pal_idx_q <= pal_idx_q + 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      dat_o <= rd_val;
    end
    if (pal_hit) begin
      pal_shadow[pal_idx_q] <= wr_val[11:0];
      pal_wr_idx_q          <= pal_idx_q;
      pal_wr_color_q        <= wr_val[11:0];
    end
  end

  assign cfg_o.rop     = vga_pkg::raster_op_e'(mode_q);
  assign cfg_o.bitmask = bitmask_q;
  assign cfg_o.start   = start_q;

  assign pal_wr_o.en    = pal_we_q;
  assign pal_wr_o.idx   = pal_wr_idx_q;
  assign pal_wr_o.color = pal_wr_color_q;

endmodule

`default_nettype wire

// File: hw/vga_cpu_mem.sv
`default_nettype none

module vga_cpu_mem (
  input  wire logic               wb_clk_i,
  input  wire logic               reset_i,
  input  wire vga_pkg::wb_req_t   req_i,
  input  wire vga_pkg::vga_cfg_t  cfg_i,
  input  wire logic               grant_i,
  input  wire vga_pkg::mem_rsp_t  rsp_i,
  output logic [15:0]             dat_o,
  output logic                    ack_o,
  output vga_pkg::mem_req_t       mem_req_o
);

  vga_pkg::cpu_state_e state_q;
  vga_pkg::cpu_state_e state_d;
  logic [15:0]         old_q;
  logic [15:0]         mask;
  logic [15:0]         rop_val;
  logic [15:0]         new_word;
  logic                full_replace;

  // A zero bitmask selects every bit
  assign mask = (cfg_i.bitmask == 16'h0) ? 16'hffff : cfg_i.bitmask;

  // Old word is not needed when every bit gets replaced
  assign full_replace = (cfg_i.rop == vga_pkg::ROP_REPLACE) && (mask == 16'hffff);

  always_comb begin
    case (cfg_i.rop)
      vga_pkg::ROP_AND: rop_val = old_q & req_i.dat;
      vga_pkg::ROP_OR:  rop_val = old_q | req_i.dat;
      vga_pkg::ROP_XOR: rop_val = old_q ^ req_i.dat;
      default:          rop_val = req_i.dat;
    endcase
  end

  assign new_word = (rop_val & mask) | (old_q & ~mask);

  always_comb begin
    state_d = state_q;
    case (state_q)
      vga_pkg::IDLE: begin
        if (req_i.stb) begin
          state_d = (req_i.we && full_replace) ? vga_pkg::WRITE : vga_pkg::READ;
        end
      end
      vga_pkg::READ: begin
        if (grant_i) begin
          state_d = vga_pkg::MODIFY;
        end
      end
      // Read data returns the cycle after the grant
      vga_pkg::MODIFY: begin
        if (rsp_i.valid) begin
          state_d = req_i.we ? vga_pkg::WRITE : vga_pkg::ACK;
        end
      end
      vga_pkg::WRITE: begin
        if (grant_i) begin
          state_d = vga_pkg::ACK;
        end
      end
      default: state_d = vga_pkg::IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q <= vga_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if ((state_q == vga_pkg::MODIFY) && rsp_i.valid) begin
      old_q <= rsp_i.dat;
    end
  end

  assign dat_o = old_q;
  assign ack_o = (state_q == vga_pkg::ACK);

  // Byte selects go to the RAM so unselected bytes stay untouched
  always_comb begin
    mem_req_o.valid = (state_q == vga_pkg::READ) || (state_q == vga_pkg::WRITE);
    mem_req_o.adr   = req_i.adr[vga_pkg::VRAM_AW-1:0];
    mem_req_o.we    = (state_q == vga_pkg::WRITE);
    mem_req_o.sel   = (state_q == vga_pkg::WRITE) ? req_i.sel : 2'b11;
    mem_req_o.dat   = new_word;
  end

endmodule

`default_nettype wire

// File: hw/vga_mem_arbiter.sv
`default_nettype none

module vga_mem_arbiter (
  input  wire logic              wb_clk_i,
  input  wire logic              reset_i,
  input  wire vga_pkg::mem_req_t scan_req_i,
  input  wire vga_pkg::mem_req_t cpu_req_i,
  output logic                   scan_grant_o,
  output logic                   cpu_grant_o,
  output vga_pkg::mem_rsp_t      scan_rsp_o,
  output vga_pkg::mem_rsp_t      cpu_rsp_o,
  output vga_pkg::mem_req_t      ram_req_o,
  input  wire logic [15:0]       ram_dat_i
);

  logic scan_rd_q;
  logic cpu_rd_q;

  // Scanout always wins as it asks at most once every four cycles
  assign scan_grant_o = scan_req_i.valid;
  assign cpu_grant_o  = cpu_req_i.valid & ~scan_req_i.valid;

  assign ram_req_o = scan_req_i.valid ? scan_req_i : cpu_req_i;

  // Owner of the read data coming back next cycle
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      scan_rd_q <= 1'b0;
      cpu_rd_q  <= 1'b0;
    end else begin
      scan_rd_q <= scan_grant_o & ~scan_req_i.we;
      cpu_rd_q  <= cpu_grant_o & ~cpu_req_i.we;
    end
  end

  assign scan_rsp_o.valid = scan_rd_q;
  assign scan_rsp_o.dat   = ram_dat_i;
  assign cpu_rsp_o.valid  = cpu_rd_q;
  assign cpu_rsp_o.dat    = ram_dat_i;

endmodule

`default_nettype wire

// File: hw/vga_pkg.sv
`default_nettype none

package vga_pkg;

  // Video RAM holds 4096 words of 16 bits
  localparam int VRAM_AW = 12;
  localparam int CFG_AW = 4;

  typedef enum logic [1:0] {
    ROP_REPLACE = 2'd0,
    ROP_AND     = 2'd1,
    ROP_OR      = 2'd2,
    ROP_XOR     = 2'd3
  } raster_op_e;

  // Register map of the tagged Wishbone space
  typedef enum logic [CFG_AW-1:0] {
    CFG_MODE      = 4'd0,
    CFG_BITMASK   = 4'd1,
    CFG_START     = 4'd2,
    CFG_PAL_INDEX = 4'd3,
    CFG_PAL_DATA  = 4'd4,
    CFG_STATUS    = 4'd5
  } cfg_reg_e;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    MODIFY,
    WRITE,
    ACK
  } cpu_state_e;

  // Strobe is already qualified with cyc
  typedef struct packed {
    logic [15:0] adr;
    logic [15:0] dat;
    logic        we;
    logic [1:0]  sel;
    logic        stb;
  } wb_req_t;

  typedef struct packed {
    raster_op_e         rop;
    logic [15:0]        bitmask;
    logic [VRAM_AW-1:0] start;
  } vga_cfg_t;

  typedef struct packed {
    logic        en;
    logic [3:0]  idx;
    logic [11:0] color;
  } pal_wr_t;

  typedef struct packed {
    logic               valid;
    logic [VRAM_AW-1:0] adr;
    logic               we;
    logic [1:0]         sel;
    logic [15:0]        dat;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] dat;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/vga_scanout.sv
`default_nettype none

module vga_scanout #(
  parameter int H_ACTIVE = 160,
  parameter int H_FRONT  = 8,
  parameter int H_SYNC   = 16,
  parameter int H_BACK   = 16,
  parameter int V_ACTIVE = 100,
  parameter int V_FRONT  = 2,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 4
) (
  input  wire logic               wb_clk_i,
  input  wire logic               reset_i,
  input  wire vga_pkg::vga_cfg_t  cfg_i,
  input  wire vga_pkg::pal_wr_t   pal_wr_i,
  input  wire logic               grant_i,
  input  wire vga_pkg::mem_rsp_t  rsp_i,
  output vga_pkg::mem_req_t       mem_req_o,
  output logic                    vblank_o,
  output logic [3:0]              vga_red_o,
  output logic [3:0]              vga_green_o,
  output logic [3:0]              vga_blue_o,
  output logic                    hsync_o,
  output logic                    vsync_o
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HW = $clog2(H_TOTAL);
  localparam int VW = $clog2(V_TOTAL);

  logic [HW-1:0]               hcnt_q;
  logic [VW-1:0]               vcnt_q;
  logic [VW-1:0]               vnext;
  logic                        h_last;
  logic                        h_active;
  logic                        v_active;
  logic                        h_sync;
  logic                        v_sync;
  logic                        first_fetch;
  logic                        line_fetch;
  logic                        fetch_pend_q;
  logic [vga_pkg::VRAM_AW-1:0] fetch_adr_q;
  logic [vga_pkg::VRAM_AW-1:0] ptr_q;
  logic [15:0]                 next_word_q;
  logic [15:0]                 shift_q;
  logic [3:0]                  nib_q;
  logic [11:0]                 color_q;
  logic [11:0]                 palette [16];
  logic [1:0]                  act_q;
  logic [1:0]                  hs_q;
  logic [1:0]                  vs_q;
  logic [1:0]                  vb_q;

  assign h_last   = (hcnt_q == HW'(H_TOTAL - 1));
  assign vnext    = (vcnt_q == VW'(V_TOTAL - 1)) ? '0 : vcnt_q + 1'b1;
  assign h_active = (hcnt_q < HW'(H_ACTIVE));
  assign v_active = (vcnt_q < VW'(V_ACTIVE));
  assign h_sync   = (hcnt_q >= HW'(H_ACTIVE + H_FRONT)) &&
                    (hcnt_q < HW'(H_ACTIVE + H_FRONT + H_SYNC));
  assign v_sync   = (vcnt_q >= VW'(V_ACTIVE + V_FRONT)) &&
                    (vcnt_q < VW'(V_ACTIVE + V_FRONT + V_SYNC));

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      hcnt_q <= '0;
      vcnt_q <= '0;
    end else if (h_last) begin
      hcnt_q <= '0;
      vcnt_q <= vnext;
    end else begin
      hcnt_q <= hcnt_q + 1'b1;
    end
  end

  // Word for the first group of a line is fetched at the end of the previous one
  assign first_fetch = (hcnt_q == HW'(H_TOTAL - 4)) && (vnext < VW'(V_ACTIVE));
  assign line_fetch  = v_active && (hcnt_q < HW'(H_ACTIVE - 4)) && (hcnt_q[1:0] == 2'b00);

  // Frame words are consecutive, so a running pointer replaces the multiply
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      fetch_pend_q <= 1'b0;
      fetch_adr_q  <= '0;
      ptr_q        <= '0;
    end else if (first_fetch || line_fetch) begin
      fetch_pend_q <= 1'b1;
      if (first_fetch && (vnext == '0)) begin
        fetch_adr_q <= cfg_i.start;
        ptr_q       <= cfg_i.start + 1'b1;
      end else begin
        fetch_adr_q <= ptr_q;
        ptr_q       <= ptr_q + 1'b1;
      end
    end else if (grant_i) begin
      fetch_pend_q <= 1'b0;
    end
  end

  assign mem_req_o.valid = fetch_pend_q;
  assign mem_req_o.adr   = fetch_adr_q;
  assign mem_req_o.we    = 1'b0;
  assign mem_req_o.sel   = 2'b11;
  assign mem_req_o.dat   = 16'h0;

  always_ff @(posedge wb_clk_i) begin
    if (rsp_i.valid) begin
      next_word_q <= rsp_i.dat;
    end
    // High nibble goes out first
    if (h_active && v_active) begin
      if (hcnt_q[1:0] == 2'b00) begin
        nib_q   <= next_word_q[15:12];
        shift_q <= {next_word_q[11:0], 4'h0};
      end else begin
        nib_q   <= shift_q[15:12];
        shift_q <= {shift_q[11:0], 4'h0};
      end
    end
    if (pal_wr_i.en) begin
      palette[pal_wr_i.idx] <= pal_wr_i.color;
    end
    color_q <= palette[nib_q];
  end

  // Three stages from the counters to the pads
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      act_q       <= 2'b00;
      hs_q        <= 2'b11;
      vs_q        <= 2'b11;
      vb_q        <= 2'b00;
      hsync_o     <= 1'b1;
      vsync_o     <= 1'b1;
      vblank_o    <= 1'b0;
      vga_red_o   <= 4'h0;
      vga_green_o <= 4'h0;
      vga_blue_o  <= 4'h0;
    end else begin
      act_q    <= {act_q[0], h_active & v_active};
      hs_q     <= {hs_q[0], ~h_sync};
      vs_q     <= {vs_q[0], ~v_sync};
      vb_q     <= {vb_q[0], ~v_active};
      hsync_o  <= hs_q[1];
      vsync_o  <= vs_q[1];
      vblank_o <= vb_q[1];
      {vga_red_o, vga_green_o, vga_blue_o} <= act_q[1] ? color_q : 12'h000;
    end
  end

endmodule

`default_nettype wire

// File: hw/vga_top.sv
`default_nettype none

module vga_top #(
  // Default frame is sized to fit the on-chip video RAM
  parameter int H_ACTIVE = 160,
  parameter int H_FRONT  = 8,
  parameter int H_SYNC   = 16,
  parameter int H_BACK   = 16,
  parameter int V_ACTIVE = 100,
  parameter int V_FRONT  = 2,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 4
) (
  input  wire logic        wb_clk_i,
  input  wire logic        reset_i,
  input  wire logic [16:1] wb_adr_i,
  input  wire logic [15:0] wb_dat_i,
  input  wire logic        wb_we_i,
  input  wire logic [1:0]  wb_sel_i,
  input  wire logic        wb_tga_i,
  input  wire logic        wb_stb_i,
  input  wire logic        wb_cyc_i,
  output logic [15:0]      wb_dat_o,
  output logic             wb_ack_o,
  output logic [3:0]       vga_red_o,
  output logic [3:0]       vga_green_o,
  output logic [3:0]       vga_blue_o,
  output logic             hsync_o,
  output logic             vsync_o
);

  vga_pkg::wb_req_t  wb_req;
  vga_pkg::wb_req_t  cfg_req;
  vga_pkg::wb_req_t  cpu_req;
  vga_pkg::vga_cfg_t cfg;
  vga_pkg::pal_wr_t  pal_wr;
  vga_pkg::mem_req_t scan_mem_req;
  vga_pkg::mem_req_t cpu_mem_req;
  vga_pkg::mem_req_t ram_req;
  vga_pkg::mem_rsp_t scan_rsp;
  vga_pkg::mem_rsp_t cpu_rsp;
  logic              scan_grant;
  logic              cpu_grant;
  logic              vblank;
  logic [15:0]       ram_dat;
  logic [15:0]       cfg_dat;
  logic [15:0]       cpu_dat;
  logic              cfg_ack;
  logic              cpu_ack;

  // Tag high selects the registers, tag low the video memory
  always_comb begin
    wb_req.adr  = wb_adr_i;
    wb_req.dat  = wb_dat_i;
    wb_req.we   = wb_we_i;
    wb_req.sel  = wb_sel_i;
    wb_req.stb  = wb_stb_i & wb_cyc_i;
    cfg_req     = wb_req;
    cfg_req.stb = wb_req.stb & wb_tga_i;
    cpu_req     = wb_req;
    cpu_req.stb = wb_req.stb & ~wb_tga_i;
  end

  assign wb_dat_o = wb_tga_i ? cfg_dat : cpu_dat;
  assign wb_ack_o = wb_tga_i ? cfg_ack : cpu_ack;

  vga_config_regs u_config_regs (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .req_i    (cfg_req),
    .vblank_i (vblank),
    .dat_o    (cfg_dat),
    .ack_o    (cfg_ack),
    .cfg_o    (cfg),
    .pal_wr_o (pal_wr)
  );

  vga_cpu_mem u_cpu_mem (
    .wb_clk_i  (wb_clk_i),
    .reset_i   (reset_i),
    .req_i     (cpu_req),
    .cfg_i     (cfg),
    .grant_i   (cpu_grant),
    .rsp_i     (cpu_rsp),
    .dat_o     (cpu_dat),
    .ack_o     (cpu_ack),
    .mem_req_o (cpu_mem_req)
  );

  vga_scanout #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_scanout (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .cfg_i       (cfg),
    .pal_wr_i    (pal_wr),
    .grant_i     (scan_grant),
    .rsp_i       (scan_rsp),
    .mem_req_o   (scan_mem_req),
    .vblank_o    (vblank),
    .vga_red_o   (vga_red_o),
    .vga_green_o (vga_green_o),
    .vga_blue_o  (vga_blue_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o)
  );

  vga_mem_arbiter u_mem_arbiter (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .scan_req_i   (scan_mem_req),
    .cpu_req_i    (cpu_mem_req),
    .scan_grant_o (scan_grant),
    .cpu_grant_o  (cpu_grant),
    .scan_rsp_o   (scan_rsp),
    .cpu_rsp_o    (cpu_rsp),
    .ram_req_o    (ram_req),
    .ram_dat_i    (ram_dat)
  );

  vga_video_ram u_video_ram (
    .wb_clk_i (wb_clk_i),
    .req_i    (ram_req),
    .dat_o    (ram_dat)
  );

endmodule

`default_nettype wire

// File: hw/vga_video_ram.sv
`default_nettype none

module vga_video_ram (
  input  wire logic              wb_clk_i,
  input  wire vga_pkg::mem_req_t req_i,
  output logic [15:0]            dat_o
);

  logic [15:0] mem [2**vga_pkg::VRAM_AW];

  // Read data is registered and holds until the next read
  always_ff @(posedge wb_clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        if (req_i.sel[0]) begin
          mem[req_i.adr][7:0] <= req_i.dat[7:0];
        end
        if (req_i.sel[1]) begin
          mem[req_i.adr][15:8] <= req_i.dat[15:8];
        end
      end else begin
        dat_o <= mem[req_i.adr];
      end
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_vga -o Vtb_vga
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vga > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0

// File: src.f
hw/vga_pkg.sv
hw/vga_config_regs.sv
hw/vga_cpu_mem.sv
hw/vga_scanout.sv
hw/vga_mem_arbiter.sv
hw/vga_video_ram.sv
hw/vga_top.sv
tests/tb_vga.sv

// File: tests/tb_vga.sv
`default_nettype none

module tb_vga;

  // Small frame to keep the run short
  localparam int H_ACTIVE = 16;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 3;
  localparam int H_BACK   = 3;
  localparam int V_ACTIVE = 4;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 1;
  localparam int V_BACK   = 1;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam int WB_TIMEOUT     = 50;
  localparam int LINE_TIMEOUT   = 2 * H_TOTAL;
  localparam int FRAME_TIMEOUT  = 3 * H_TOTAL * V_TOTAL;
  localparam int MEM_MAX_CYCLES = 6;

  logic        wb_clk_i;
  logic        reset_i;
  logic [16:1] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic        wb_we_i;
  logic [1:0]  wb_sel_i;
  logic        wb_tga_i;
  logic        wb_stb_i;
  logic        wb_cyc_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic [3:0]  vga_red_o;
  logic [3:0]  vga_green_o;
  logic [3:0]  vga_blue_o;
  logic        hsync_o;
  logic        vsync_o;

  int          value_errs;
  int          other_errs;
  int          pix_count;
  logic        pix_check_en;
  logic [15:0] lfsr_q;

  // Reference state of registers, palette and video words
  logic [1:0]  cur_rop;
  logic [15:0] cur_mask;
  logic [11:0] cur_start;
  logic [3:0]  pal_idx;
  logic [11:0] pal_model [16];
  logic [15:0] vram_model [4096];

  // Monitor state
  int          hpos;
  int          hrise_cnt;
  int          hs_low_len;
  int          vs_hpulses;
  int          line_n;
  int          px_n;
  int          word_adr;
  logic        hs_prev;
  logic        vs_prev;
  logic        frame_ok;
  logic [11:0] mon_start;
  logic [15:0] word;
  logic [3:0]  nib;

  vga_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) UUT (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_we_i     (wb_we_i),
    .wb_sel_i    (wb_sel_i),
    .wb_tga_i    (wb_tga_i),
    .wb_stb_i    (wb_stb_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .vga_red_o   (vga_red_o),
    .vga_green_o (vga_green_o),
    .vga_blue_o  (vga_blue_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever begin
      #10 wb_clk_i = ~wb_clk_i;
    end
  end

  // Ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
                              !(wb_ack_o && $past(wb_ack_o)))
    else begin
      other_errs++;
      $display("wb_ack_o stayed high for more than one cycle at %0t", $time);
    end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // Raster op under the bitmask, then byte selects
  function automatic logic [15:0] expected_write(input logic [15:0] old_w,
                                                 input logic [15:0] dat,
                                                 input logic [1:0]  sel,
                                                 input logic [1:0]  rop,
                                                 input logic [15:0] bitmask);
    logic [15:0] m;
    logic [15:0] r;
    logic [15:0] w;
    logic [15:0] res;
    m = (bitmask == 16'h0) ? 16'hffff : bitmask;
    case (vga_pkg::raster_op_e'(rop))
      vga_pkg::ROP_AND: r = old_w & dat;
      vga_pkg::ROP_OR:  r = old_w | dat;
      vga_pkg::ROP_XOR: r = old_w ^ dat;
      default:          r = dat;
    endcase
    w = (r & m) | (old_w & ~m);
    res[15:8] = sel[1] ? w[15:8] : old_w[15:8];
    res[7:0]  = sel[0] ? w[7:0] : old_w[7:0];
    return res;
  endfunction

  function automatic logic [15:0] reg_model(input vga_pkg::cfg_reg_e r);
    case (r)
      vga_pkg::CFG_MODE:      return {14'h0, cur_rop};
      vga_pkg::CFG_BITMASK:   return cur_mask;
      vga_pkg::CFG_START:     return {4'h0, cur_start};
      vga_pkg::CFG_PAL_INDEX: return {12'h0, pal_idx};
      vga_pkg::CFG_PAL_DATA:  return {4'h0, pal_model[pal_idx]};
      default:                return 16'h0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got == exp) else begin
      value_errs++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic wb_cycle(input logic tag, input logic we, input logic [15:0] adr,
                          input logic [15:0] dat, input logic [1:0] sel,
                          output logic [15:0] rdat, output int cycles);
    @(negedge wb_clk_i);
    wb_tga_i = tag;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    @(negedge wb_clk_i);
    cycles = 1;
    while (!wb_ack_o && cycles < WB_TIMEOUT) begin
      @(negedge wb_clk_i);
      cycles++;
    end
    if (!wb_ack_o) begin
      other_errs++;
      $display("Timeout: no Wishbone ack for access to address %h (tag %0d)", adr, tag);
    end
    rdat     = wb_dat_o;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic reg_write(input vga_pkg::cfg_reg_e r, input logic [15:0] dat);
    logic [15:0] rd;
    int          cyc;
    wb_cycle(1'b1, 1'b1, {12'h0, r}, dat, 2'b11, rd, cyc);
    check_value("wb_ack_o latency", 16'(cyc), 16'd1);
    case (r)
      vga_pkg::CFG_MODE:      cur_rop = dat[1:0];
      vga_pkg::CFG_BITMASK:   cur_mask = dat;
      vga_pkg::CFG_START:     cur_start = dat[11:0];
      vga_pkg::CFG_PAL_INDEX: pal_idx = dat[3:0];
      vga_pkg::CFG_PAL_DATA: begin
        pal_model[pal_idx] = dat[11:0];
        pal_idx = pal_idx + 4'd1;
      end
      default: ;
    endcase
  endtask

  task automatic reg_read(input vga_pkg::cfg_reg_e r, output logic [15:0] rd);
    int cyc;
    wb_cycle(1'b1, 1'b0, {12'h0, r}, 16'h0, 2'b11, rd, cyc);
    check_value("wb_ack_o latency", 16'(cyc), 16'd1);
  endtask

  task automatic reg_check(input vga_pkg::cfg_reg_e r);
    logic [15:0] rd;
    reg_read(r, rd);
    check_value($sformatf("wb_dat_o (%s)", r.name()), rd, reg_model(r));
  endtask

  task automatic check_latency(input int cyc);
    assert (cyc <= MEM_MAX_CYCLES) else begin
      other_errs++;
      $display("Video memory ack took %0d cycles, more than %0d", cyc, MEM_MAX_CYCLES);
    end
  endtask

  task automatic mem_write(input logic [11:0] adr, input logic [15:0] dat,
                           input logic [1:0] sel);
    logic [15:0] rd;
    int          cyc;
    wb_cycle(1'b0, 1'b1, {4'h0, adr}, dat, sel, rd, cyc);
    check_latency(cyc);
    vram_model[adr] = expected_write(vram_model[adr], dat, sel, cur_rop, cur_mask);
  endtask

  task automatic mem_check(input logic [11:0] adr);
    logic [15:0] rd;
    int          cyc;
    wb_cycle(1'b0, 1'b0, {4'h0, adr}, 16'h0, 2'b11, rd, cyc);
    check_latency(cyc);
    check_value($sformatf("wb_dat_o (word %h)", adr), rd, vram_model[adr]);
  endtask

  task automatic wait_sync_rise(input logic vert);
    logic prev;
    logic cur;
    logic done;
    int   n;
    int   limit;
    prev  = vert ? vsync_o : hsync_o;
    done  = 1'b0;
    n     = 0;
    limit = vert ? FRAME_TIMEOUT : LINE_TIMEOUT;
    while (!done && n < limit) begin
      @(negedge wb_clk_i);
      n++;
      cur  = vert ? vsync_o : hsync_o;
      done = cur && !prev;
      prev = cur;
    end
    if (!done) begin
      other_errs++;
      $display("Timeout: no rising edge on %s", vert ? "vsync_o" : "hsync_o");
    end
  endtask

  task automatic wait_vsync_low();
    int n;
    n = 0;
    while (vsync_o && n < FRAME_TIMEOUT) begin
      @(negedge wb_clk_i);
      n++;
    end
    if (vsync_o) begin
      other_errs++;
      $display("Timeout: vsync_o never went low");
    end
  endtask

  // Sync pulse widths, blanking and pixel colours seen at the pads
  always @(negedge wb_clk_i) begin
    if (reset_i) begin
      hs_prev    = 1'b1;
      vs_prev    = 1'b1;
      frame_ok   = 1'b0;
      hpos       = 0;
      hrise_cnt  = 0;
      hs_low_len = 0;
      vs_hpulses = 0;
      mon_start  = '0;
    end else begin
      if (!hsync_o) begin
        hs_low_len++;
      end
      if (!hsync_o && hs_prev && !vsync_o) begin
        vs_hpulses++;
      end
      if (hsync_o && !hs_prev) begin
        check_value("hsync_o low cycles", 16'(hs_low_len), 16'(H_SYNC));
        hs_low_len = 0;
        hpos       = 0;
        hrise_cnt++;
      end else begin
        hpos++;
      end
      if (vsync_o && !vs_prev) begin
        if (frame_ok) begin
          check_value("hsync_o pulses per frame", 16'(hrise_cnt), 16'(V_TOTAL));
          check_value("vsync_o low lines", 16'(vs_hpulses), 16'(V_SYNC));
        end
        frame_ok   = 1'b1;
        hrise_cnt  = 0;
        vs_hpulses = 0;
        mon_start  = cur_start;
      end
      line_n = hrise_cnt - V_BACK;
      px_n   = hpos - H_BACK;
      if (frame_ok) begin
        if (line_n >= 0 && line_n < V_ACTIVE && px_n >= 0 && px_n < H_ACTIVE) begin
          if (pix_check_en) begin
            word_adr = (int'(mon_start) + line_n * (H_ACTIVE / 4) + px_n / 4) % 4096;
            word     = vram_model[word_adr];
            nib      = 4'(word >> (4 * (3 - (px_n % 4))));
            check_value($sformatf("vga_red/green/blue_o line %0d pixel %0d", line_n, px_n),
                        {4'h0, vga_red_o, vga_green_o, vga_blue_o}, {4'h0, pal_model[nib]});
            pix_count++;
          end
        end else begin
          check_value("vga_red/green/blue_o outside active area",
                      {4'h0, vga_red_o, vga_green_o, vga_blue_o}, 16'h0);
        end
      end
      hs_prev = hsync_o;
      vs_prev = vsync_o;
    end
  end

  initial begin
    logic [15:0] d;
    logic [15:0] rd;
    logic [3:0]  idx0;
    int          base_count;
    reset_i      = 1'b1;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    wb_we_i      = 1'b0;
    wb_sel_i     = 2'b00;
    wb_tga_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_cyc_i     = 1'b0;
    value_errs   = 0;
    other_errs   = 0;
    pix_count    = 0;
    pix_check_en = 1'b0;
    lfsr_q       = 16'd34258;
    cur_rop      = 2'b00;
    cur_mask     = 16'h0;
    cur_start    = '0;
    pal_idx      = 4'h0;
    for (int i = 0; i < 16; i++) begin
      pal_model[i] = 12'h0;
    end
    repeat (5) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    reset_i = 1'b0;

    // Register readback masked to each width
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < 4; j++) begin
        reg_write(vga_pkg::cfg_reg_e'(4'(j)), rand_bits(16));
        reg_check(vga_pkg::cfg_reg_e'(4'(j)));
      end
      idx0 = 4'(rand_bits(4));
      reg_write(vga_pkg::CFG_PAL_INDEX, {12'h0, idx0});
      reg_write(vga_pkg::CFG_PAL_DATA, rand_bits(16));
      reg_check(vga_pkg::CFG_PAL_INDEX);
      reg_write(vga_pkg::CFG_PAL_INDEX, {12'h0, idx0});
      reg_check(vga_pkg::CFG_PAL_DATA);
    end
    wait_vsync_low();
    reg_read(vga_pkg::CFG_STATUS, rd);
    check_value("wb_dat_o (CFG_STATUS in blank)", rd, 16'h1);
    wait_sync_rise(1'b1);
    wait_sync_rise(1'b0);
    wait_sync_rise(1'b0);
    reg_read(vga_pkg::CFG_STATUS, rd);
    check_value("wb_dat_o (CFG_STATUS in active)", rd, 16'h0);

    // Replace writes with random byte selects
    reg_write(vga_pkg::CFG_MODE, 16'h0);
    reg_write(vga_pkg::CFG_BITMASK, 16'hffff);
    for (int a = 0; a < 64; a++) begin
      mem_write(12'(a), rand_bits(16), 2'b11);
    end
    for (int k = 0; k < 40; k++) begin
      d = rand_bits(6);
      mem_write(d[11:0], rand_bits(16), 2'(rand_bits(2)));
      mem_check(d[11:0]);
    end

    // AND, OR and XOR under random bitmasks
    for (int k = 0; k < 48; k++) begin
      reg_write(vga_pkg::CFG_MODE, 16'((k % 3) + 1));
      reg_write(vga_pkg::CFG_BITMASK, rand_bits(16));
      d = rand_bits(6);
      mem_write(d[11:0], rand_bits(16), 2'(rand_bits(2)));
      mem_check(d[11:0]);
    end

    // Palette through the auto-incrementing index, then a fresh frame
    reg_write(vga_pkg::CFG_MODE, 16'h0);
    reg_write(vga_pkg::CFG_BITMASK, 16'hffff);
    reg_write(vga_pkg::CFG_PAL_INDEX, 16'h0);
    for (int i = 0; i < 16; i++) begin
      reg_write(vga_pkg::CFG_PAL_DATA, rand_bits(16));
    end
    reg_write(vga_pkg::CFG_START, 16'h0);
    for (int a = 0; a < 16; a++) begin
      mem_write(12'(a), rand_bits(16), 2'b11);
    end
    wait_sync_rise(1'b1);
    wait_sync_rise(1'b1);
    pix_check_en = 1'b1;
    base_count   = pix_count;
    wait_sync_rise(1'b1);
    wait_sync_rise(1'b1);
    pix_check_en = 1'b0;
    check_value("pixels checked in two frames", 16'(pix_count - base_count),
                16'(2 * H_ACTIVE * V_ACTIVE));

    // CPU traffic below the frame while it is scanned from word 32
    reg_write(vga_pkg::CFG_START, 16'd32);
    wait_sync_rise(1'b1);
    wait_sync_rise(1'b1);
    pix_check_en = 1'b1;
    base_count   = pix_count;
    for (int k = 0; k < 40; k++) begin
      d = rand_bits(5);
      if (rand_bits(1) != 16'h0) begin
        reg_write(vga_pkg::CFG_MODE, rand_bits(2));
        reg_write(vga_pkg::CFG_BITMASK, rand_bits(16));
        mem_write(d[11:0], rand_bits(16), 2'(rand_bits(2)));
      end
      mem_check(d[11:0]);
    end
    wait_sync_rise(1'b1);
    pix_check_en = 1'b0;
    assert (pix_count > base_count) else begin
      other_errs++;
      $display("No pixels were checked while CPU traffic was running");
    end

    $display("Errors: %0d value, %0d other; %0d pixels checked",
             value_errs, other_errs, pix_count);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
